//--- logic/rot_pkg.sv
//////////////////////////////
// shared types, function codes and stage payloads for the
// pipelined rotate unit, imported by every stage and the testbench
//////////////////////////////
`default_nettype none

package rot_pkg;

  // widths and ring lengths
  localparam int WORD_BITS = 16;
  localparam int BYTE_BITS = 8;
  localparam int RING_WORD = 17;  // word plus carry
  localparam int RING_BYTE = 9;   // byte plus carry

  typedef logic [WORD_BITS-1:0] word_t;     // operand / result
  typedef logic [4:0]           count_t;    // count as issued
  typedef logic [4:0]           rot_amt_t;  // right distance, 0..16
  typedef logic [1:0]           rot_func_t; // bit1 thru carry, bit0 left

  localparam rot_func_t FUNC_ROR = 2'd0;
  localparam rot_func_t FUNC_ROL = 2'd1;
  localparam rot_func_t FUNC_RCR = 2'd2;
  localparam rot_func_t FUNC_RCL = 2'd3;

  typedef struct packed {
    word_t     x;        // operand, byte ops use x[7:0]
    count_t    y;
    rot_func_t func;
    logic      cfi;
    logic      ofi;
    logic      word_op;  // 1 = 16 bit
  } rot_req_t;

  typedef struct packed {
    word_t     x;
    rot_amt_t  amt;        // decoded right rotate distance
    rot_func_t func;
    logic      cfi;
    logic      ofi;
    logic      word_op;
    logic      unchanged;  // zero count, flags pass through
  } rot_dec_t;

  typedef struct packed {
    word_t     out;  // merged result
    logic      co;   // carry slot of the ring
    rot_func_t func;
    logic      cfi;
    logic      ofi;
    logic      word_op;
    logic      unchanged;
  } rot_mid_t;

  typedef struct packed {
    word_t out;
    logic  cfo;
    logic  ofo;
  } rot_rsp_t;

endpackage

`default_nettype wire

//--- logic/rot_rxr.sv
//////////////////////////////
// combinational right rotate over a 16/17 or 8/9 bit ring
// through adds the carry in as the top ring position
//////////////////////////////
`default_nettype none

module rot_rxr
  import rot_pkg::*;
(
  input  word_t    x,
  input  logic     ci,
  input  logic     through,
  input  logic     word_op,
  input  rot_amt_t amt,
  output word_t    w,
  output logic     co
);

  logic [RING_WORD-1:0]   ring17;
  logic [2*RING_WORD-1:0] dbl17;
  logic [2*WORD_BITS-1:0] dbl16;
  logic [RING_BYTE-1:0]   ring9;
  logic [2*RING_BYTE-1:0] dbl9;
  logic [2*BYTE_BITS-1:0] dbl8;

  // rotate == shift of the doubled ring, keep low ring bits
  assign ring17 = {ci, x};
  assign dbl17  = {ring17, ring17} >> amt;
  assign dbl16  = {x, x} >> amt;

  assign ring9  = {ci, x[BYTE_BITS-1:0]};
  assign dbl9   = {ring9, ring9} >> amt;
  assign dbl8   = {x[BYTE_BITS-1:0], x[BYTE_BITS-1:0]} >> amt;

  always_comb begin
    if (word_op) begin
      if (through) begin
        w  = dbl17[WORD_BITS-1:0];
        co = dbl17[RING_WORD-1];  // bit left in carry slot
      end else begin
        w  = dbl16[WORD_BITS-1:0];
        co = ci;                  // no carry in ring
      end
    end else begin
      // upper byte is don't-care, merged later
      if (through) begin
        w  = {8'h00, dbl9[BYTE_BITS-1:0]};
        co = dbl9[RING_BYTE-1];
      end else begin
        w  = {8'h00, dbl8[BYTE_BITS-1:0]};
        co = ci;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/rot_count_stage.sv
//////////////////////////////
// stage 1 of the rotate pipe
// turns count + function into a right rotate distance, one slot
//////////////////////////////
`default_nettype none

module rot_count_stage
  import rot_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     in_valid,
  output logic     in_ready,
  input  rot_req_t in_req,
  output logic     dec_valid,
  input  logic     dec_ready,
  output rot_dec_t dec
);

  count_t     y;
  logic [3:0] y4;        // low nibble, byte ops only look here
  logic [3:0] neg4;      // -y mod 16
  logic [2:0] neg3;      // -y mod 8
  logic [5:0] rcl_wide;  // 34 - y needs 6 bits
  rot_amt_t   amt_word;
  rot_amt_t   amt_byte;
  rot_dec_t   dec_d;
  logic       accept;

  assign y        = in_req.y;
  assign y4       = y[3:0];
  assign neg4     = 4'd0 - y4;
  assign neg3     = 3'd0 - y[2:0];
  assign rcl_wide = 6'(2 * RING_WORD) - {1'b0, y};

  // word distances, ring of 16 or 17
  always_comb begin
    case (in_req.func)
      FUNC_ROR: amt_word = {1'b0, y4};  // mod 16
      FUNC_ROL: amt_word = {1'b0, neg4};  // left n == right -n
      FUNC_RCR: amt_word = (y <= 5'(WORD_BITS)) ? y : y - 5'(RING_WORD);
      default:  amt_word = (y <= 5'(RING_WORD)) ? 5'(RING_WORD) - y
                                                : rcl_wide[4:0];
    endcase
  end

  // byte distances, ring of 8 or 9, from the low nibble
  always_comb begin
    case (in_req.func)
      FUNC_ROR: amt_byte = {2'b00, y[2:0]};
      FUNC_ROL: amt_byte = {2'b00, neg3};
      FUNC_RCR: amt_byte = (y4 <= 4'(BYTE_BITS)) ? {1'b0, y4}
                                                 : {1'b0, y4} - 5'(RING_BYTE);
      default:  amt_byte = (y4 <= 4'(RING_BYTE)) ? 5'(RING_BYTE) - {1'b0, y4}
                                                 : 5'(2 * RING_BYTE) - {1'b0, y4};
    endcase
  end

  always_comb begin
    dec_d.x         = in_req.x;
    dec_d.amt       = in_req.word_op ? amt_word : amt_byte;
    dec_d.func      = in_req.func;
    dec_d.cfi       = in_req.cfi;
    dec_d.ofi       = in_req.ofi;
    dec_d.word_op   = in_req.word_op;
    // zero count keeps flags, byte mode ignores y[4]
    dec_d.unchanged = in_req.word_op ? (y == 5'd0) : (y4 == 4'd0);
  end

  // slot is free when empty or draining this cycle
  assign in_ready = !dec_valid || dec_ready;
  assign accept   = in_valid && in_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      dec_valid <= 1'b0;
    end else if (in_ready) begin
      dec_valid <= in_valid;  // load or go empty
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      dec <= dec_d;
    end
  end

endmodule

`default_nettype wire

//--- logic/rot_shift_stage.sv
//////////////////////////////
// stage 2 of the rotate pipe
// runs the rotate network, merges byte results into the word
//////////////////////////////
`default_nettype none

module rot_shift_stage
  import rot_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     dec_valid,
  output logic     dec_ready,
  input  rot_dec_t dec,
  output logic     mid_valid,
  input  logic     mid_ready,
  output rot_mid_t mid
);

  word_t    rot_w;
  logic     rot_co;
  rot_mid_t mid_d;
  logic     accept;

  rot_rxr i_rot_rxr (
    .x       (dec.x),
    .ci      (dec.cfi),
    .through (dec.func[1]),  // rcr / rcl
    .word_op (dec.word_op),
    .amt     (dec.amt),
    .w       (rot_w),
    .co      (rot_co)
  );

  always_comb begin
    // byte op: upper byte of operand kept as is
    mid_d.out       = dec.word_op ? rot_w : {dec.x[15:8], rot_w[7:0]};
    mid_d.co        = rot_co;
    mid_d.func      = dec.func;
    mid_d.cfi       = dec.cfi;
    mid_d.ofi       = dec.ofi;
    mid_d.word_op   = dec.word_op;
    mid_d.unchanged = dec.unchanged;
  end

  assign dec_ready = !mid_valid || mid_ready;
  assign accept    = dec_valid && dec_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      mid_valid <= 1'b0;
    end else if (dec_ready) begin
      mid_valid <= dec_valid;
    end
  end

  // payload, no reset
  always_ff @(posedge clk) begin
    if (accept) begin
      mid <= mid_d;
    end
  end

endmodule

`default_nettype wire

//--- logic/rot_flag_stage.sv
//////////////////////////////
// stage 3 of the rotate pipe
// builds CF and OF, holds the response for the output port
//////////////////////////////
`default_nettype none

module rot_flag_stage
  import rot_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     mid_valid,
  output logic     mid_ready,
  input  rot_mid_t mid,
  output logic     out_valid,
  input  logic     out_ready,
  output rot_rsp_t out_rsp
);

  logic     msb;    // top result bit, 15 or 7
  logic     msb2;   // next one down
  logic     cf;
  logic     of;
  rot_rsp_t rsp_d;
  logic     accept;

  assign msb  = mid.word_op ? mid.out[15] : mid.out[7];
  assign msb2 = mid.word_op ? mid.out[14] : mid.out[6];

  // carry
  always_comb begin
    case (mid.func)
      FUNC_RCR, FUNC_RCL: cf = mid.co;      // out of the ring
      FUNC_ROL:           cf = mid.out[0];  // wrapped into bit 0
      default:            cf = msb;         // ror, wrapped into top
    endcase
  end

  // overflow, bit 0 of func = left
  assign of = mid.func[0] ? (cf ^ msb) : (msb ^ msb2);

  always_comb begin
    rsp_d.out = mid.out;
    rsp_d.cfo = mid.unchanged ? mid.cfi : cf;
    rsp_d.ofo = mid.unchanged ? mid.ofi : of;
  end

  assign mid_ready = !out_valid || out_ready;
  assign accept    = mid_valid && mid_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (mid_ready) begin
      out_valid <= mid_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      out_rsp <= rsp_d;  // held while out_ready low
    end
  end

endmodule

`default_nettype wire

//--- logic/rot_unit.sv
//////////////////////////////
// pipelined rotate unit top
// decode -> rotate -> flags, valid/ready on every link
//////////////////////////////
`default_nettype none

module rot_unit
  import rot_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     in_valid,
  output logic     in_ready,
  input  rot_req_t in_req,
  output logic     out_valid,
  input  logic     out_ready,
  output rot_rsp_t out_rsp
);

  logic     dec_valid;
  logic     dec_ready;
  rot_dec_t dec;      // stage 1 -> 2
  logic     mid_valid;
  logic     mid_ready;
  rot_mid_t mid;      // stage 2 -> 3

  rot_count_stage i_rot_count_stage (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_req    (in_req),
    .dec_valid (dec_valid),
    .dec_ready (dec_ready),
    .dec       (dec)
  );

  rot_shift_stage i_rot_shift_stage (
    .clk       (clk),
    .reset     (reset),
    .dec_valid (dec_valid),
    .dec_ready (dec_ready),
    .dec       (dec),
    .mid_valid (mid_valid),
    .mid_ready (mid_ready),
    .mid       (mid)
  );

  rot_flag_stage i_rot_flag_stage (
    .clk       (clk),
    .reset     (reset),
    .mid_valid (mid_valid),
    .mid_ready (mid_ready),
    .mid       (mid),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_rsp   (out_rsp)
  );

endmodule

`default_nettype wire

//--- verif/rot_unit_props.sv
//////////////////////////////
// handshake and reset checks on the rotate unit ports
// bound into rot_unit below
//////////////////////////////
`default_nettype none

module rot_unit_props
  import rot_pkg::*;
(
  input logic     clk,
  input logic     reset,
  input logic     in_ready,
  input logic     out_valid,
  input logic     out_ready,
  input rot_rsp_t out_rsp
);

  // nothing out while reset held or on the cycle after
  reset_idle: assert property (@(posedge clk) reset |=> !out_valid)
    else $error("out_valid high during or right after reset");

  // stalled response holds
  stall_hold: assert property (@(posedge clk) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(out_rsp))
    else $error("response changed while out_ready was low");

  // open output lets every slot move
  ready_chain: assert property (@(posedge clk) disable iff (reset) out_ready |-> in_ready)
    else $error("in_ready low while out_ready high");

endmodule

bind rot_unit rot_unit_props i_rot_unit_props (
  .clk       (clk),
  .reset     (reset),
  .in_ready  (in_ready),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .out_rsp   (out_rsp)
);

`default_nettype wire

//--- verif/rot_unit_tb.sv
//////////////////////////////
// testbench for the rotate unit, replays the golden vectors
// with random input gaps and output stalls, checks responses in order
//////////////////////////////
`default_nettype none

module rot_unit_tb
  import rot_pkg::*;
();

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 5;
  localparam int DRIVE_DELAY  = 2;     // after the rising edge
  localparam int FIELDS       = 10;    // columns per golden line
  localparam int MEM_DEPTH    = 1024;  // 10 bit address
  localparam int MAX_VEC      = MEM_DEPTH / FIELDS;

  logic     clk;
  logic     reset;
  logic     in_valid;
  logic     in_ready;
  rot_req_t in_req;
  logic     out_valid;
  logic     out_ready;
  rot_rsp_t out_rsp;

  // id x y func word_op cfi ofi out cfo ofo, one entry per column
  logic [15:0] vec_mem [0:MEM_DEPTH-1];
  int          num_vec = 0;
  int          checked = 0;  // responses compared so far
  int          checks  = 0;
  int          errors  = 0;
  logic [31:0] rng     = 32'd9;

  rot_unit i_rot_unit (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_req    (in_req),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_rsp   (out_rsp)
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] v;
    v = s ^ (s << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  // column col of vector n
  function automatic logic [15:0] golden_field(input int n, input int col);
    return vec_mem[10'(n * FIELDS + col)];
  endfunction

  task automatic present_vector(input int n);
    in_req.x       = golden_field(n, 1);
    in_req.y       = 5'(golden_field(n, 2));
    in_req.func    = 2'(golden_field(n, 3));
    in_req.word_op = golden_field(n, 4) != 16'd0;
    in_req.cfi     = golden_field(n, 5) != 16'd0;
    in_req.ofi     = golden_field(n, 6) != 16'd0;
  endtask

  task automatic check_field(input string name, input logic [15:0] expected,
                             input logic [15:0] actual);
    checks++;
    if (actual !== expected) begin
      $display("CHECK FAILED time=%0t %s expected %h got %h", $time, name, expected, actual);
      errors++;
    end
  endtask

  initial begin : main
    int   idx;
    logic offer_taken;
    idx       = 0;
    reset     = 1'b1;
    in_valid  = 1'b0;
    in_req    = '0;
    out_ready = 1'b0;
    $readmemh("verif/rot_golden.hex", vec_mem);
    // ids start at 1, unloaded entries end the list
    while (num_vec < MAX_VEC && golden_field(num_vec, 0) != 16'd0) begin
      num_vec++;
    end
    if (num_vec == 0) begin
      $display("no vectors could be read from verif/rot_golden.hex");
    end else begin
      repeat (RESET_CYCLES) @(posedge clk);
      #DRIVE_DELAY;
      reset = 1'b0;
      while (checked < num_vec) begin
        @(negedge clk);
        offer_taken = in_valid && in_ready;  // transfer on the coming edge
        @(posedge clk);
        #DRIVE_DELAY;
        if (offer_taken) begin
          idx++;
        end
        rng       = xorshift32(rng);
        out_ready = (rng[1:0] != 2'b00);  // stall about one cycle in four
        // a pending request stays put until taken
        if (!in_valid || offer_taken) begin
          if (idx < num_vec && rng[4:3] != 2'b00) begin
            present_vector(idx);
            in_valid = 1'b1;
          end else begin
            in_valid = 1'b0;  // idle gap or all sent
          end
        end
      end
      out_ready = 1'b1;
      repeat (4) @(posedge clk);  // catch stray extra responses
    end
    $display("summary: %0d vectors, %0d responses, %0d checks, %0d errors",
             num_vec, checked, checks, errors);
    if (num_vec > 0 && checked == num_vec && errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin : monitor
    int test_start;   // first vector of running test
    int test_errors;  // error count when it began
    test_start  = 0;
    test_errors = 0;
    forever begin
      @(negedge clk);
      // payload stable here, it moves on the next edge
      if (!reset && out_valid && out_ready) begin
        if (checked >= num_vec) begin
          $display("unexpected extra response at time %0t", $time);
          errors++;
        end else begin
          check_field("out_rsp.out", golden_field(checked, 7), out_rsp.out);
          check_field("out_rsp.cfo", golden_field(checked, 8), {15'd0, out_rsp.cfo});
          check_field("out_rsp.ofo", golden_field(checked, 9), {15'd0, out_rsp.ofo});
          checked++;
          if (checked == num_vec
              || golden_field(checked, 0) != golden_field(checked - 1, 0)) begin
            $display("test %0d done: %0d vectors, %0d errors", golden_field(checked - 1, 0),
                     checked - test_start, errors - test_errors);
            test_start  = checked;
            test_errors = errors;
          end
        end
      end
    end
  end

  // eight cycles per vector covers gaps, stalls and pipe latency
  initial begin : watchdog
    wait (num_vec > 0);
    #(num_vec * CLK_PERIOD * 8 + (RESET_CYCLES + 4) * CLK_PERIOD);
    $display("timeout: only %0d of %0d responses arrived", checked, num_vec);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/rot_golden.hex
// id x y func word_op cfi ofi | expected out cfo ofo
// func 0 ror, 1 rol, 2 rcr, 3 rcl; word_op 1 = 16 bit
1 1234 04 0 1 0 0 4123 0 1
1 1234 04 1 1 0 0 2341 1 1
1 8001 01 1 1 0 0 0003 1 1
1 A5C3 14 0 1 0 0 3A5C 0 0
1 A5C3 1F 1 1 0 0 D2E1 1 0
1 3C96 03 0 0 0 0 3CD2 1 0
1 3C96 03 1 0 0 0 3CB4 0 1
1 FF01 0D 0 0 0 0 FF08 0 0
1 4000 10 1 1 1 1 4000 0 0
2 0001 01 2 1 1 0 8000 1 1
2 8000 01 3 1 0 0 0000 1 1
2 1234 11 2 1 1 0 1234 1 0
2 F0F5 14 2 1 1 0 7E1E 1 1
2 0003 1F 3 1 1 0 E000 0 1
2 5A81 09 2 0 0 0 5A81 0 1
2 5A81 01 3 0 0 0 5A02 1 1
2 00C3 1B 2 0 1 0 00F0 1 0
2 FF10 0E 3 0 1 0 FF11 0 0
3 BEEF 00 0 1 1 0 BEEF 1 0
3 1357 00 3 1 0 1 1357 0 1
3 ABCD 10 1 0 1 1 ABCD 1 1
3 1280 10 2 0 0 1 1280 0 1
4 C3A5 04 1 0 1 1 C35A 0 0
4 7E7F 09 3 0 1 0 7E7F 1 1
4 8001 07 0 0 0 0 8002 0 0
5 0001 01 0 1 0 0 8000 1 1
5 4000 01 1 1 0 0 8000 0 1
5 8000 01 2 1 0 0 4000 0 1
5 0040 01 3 0 0 0 0080 0 1

//--- filelist.f
logic/rot_pkg.sv
logic/rot_rxr.sv
logic/rot_count_stage.sv
logic/rot_shift_stage.sv
logic/rot_flag_stage.sv
logic/rot_unit.sv
verif/rot_unit_props.sv
verif/rot_unit_tb.sv

//--- run.sh
#!/bin/sh
# build and run the rotate unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module rot_unit_tb -f filelist.f \
  && ./obj_dir/Vrot_unit_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qs "^=== PASS ===$" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
